/* build.f */
source/text_overlay_pkg.sv
source/text_field_window.sv
source/name_rom.sv
source/hp_digit_format.sv
source/text_overlay.sv
tests/text_overlay_asserts.sv
tests/text_overlay_tb.sv

/* build.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module text_overlay_tb -o text_overlay_sim \
   && ./obj_dir/text_overlay_sim +verilator+error+limit+1000 \
      | tee /dev/stderr | grep -qx "TEST OK" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* source/hp_digit_format.sv */
`timescale 1ns/1ps

module hp_digit_format (
   input  text_overlay_pkg::hp_t    cur_hp,
   input  text_overlay_pkg::hp_t    max_hp,
   input  text_overlay_pkg::slot_t  slot,
   output text_overlay_pkg::ascii_t hp_char
);

   localparam text_overlay_pkg::hp_t HUNDRED = 8'd100;
   localparam text_overlay_pkg::hp_t TEN = 8'd10;

   // decimal digits, hundreds only ever 0 or 1
   text_overlay_pkg::hp_t cur_tens;
   text_overlay_pkg::hp_t cur_ones;
   text_overlay_pkg::hp_t max_tens;
   text_overlay_pkg::hp_t max_ones;
   logic cur_big;
   logic max_big;

   // readout characters for each side of the slash
   text_overlay_pkg::ascii_t cur_h_char;
   text_overlay_pkg::ascii_t cur_t_char;
   text_overlay_pkg::ascii_t max_h_char;

   assign cur_big = (cur_hp >= HUNDRED);
   assign max_big = (max_hp >= HUNDRED);

   assign cur_tens = (cur_hp % HUNDRED) / TEN;
   assign cur_ones = cur_hp % TEN;
   assign max_tens = (max_hp % HUNDRED) / TEN;
   assign max_ones = max_hp % TEN;

   // leading '1' or blank
   assign cur_h_char = cur_big ? text_overlay_pkg::ASCII_ONE : text_overlay_pkg::ASCII_SPACE;
   assign max_h_char = max_big ? text_overlay_pkg::ASCII_ONE : text_overlay_pkg::ASCII_SPACE;

   // current value blanks a leading zero tens digit
   // max keeps its zero, so 5/5 reads "  5/ 05"
   assign cur_t_char = (!cur_big && cur_tens == '0) ? text_overlay_pkg::ASCII_SPACE :
                       text_overlay_pkg::ASCII_ZERO + text_overlay_pkg::ascii_t'(cur_tens);

   // slot order "ccc/mmm"
   always_comb begin
      case (slot)
         4'd0:    hp_char = cur_h_char;
         4'd1:    hp_char = cur_t_char;
         4'd2:    hp_char = text_overlay_pkg::ASCII_ZERO + text_overlay_pkg::ascii_t'(cur_ones);
         4'd3:    hp_char = text_overlay_pkg::ASCII_SLASH;
         4'd4:    hp_char = max_h_char;
         4'd5:    hp_char = text_overlay_pkg::ASCII_ZERO + text_overlay_pkg::ascii_t'(max_tens);
         4'd6:    hp_char = text_overlay_pkg::ASCII_ZERO + text_overlay_pkg::ascii_t'(max_ones);
         default: hp_char = text_overlay_pkg::ASCII_SPACE;
      endcase
   end

endmodule

/* source/name_rom.sv */
`timescale 1ns/1ps

module name_rom (
   input  text_overlay_pkg::poke_id_t poke_id,
   input  text_overlay_pkg::slot_t    name_slot,
   input  text_overlay_pkg::move_id_t move_id,
   input  text_overlay_pkg::slot_t    move_slot,
   output text_overlay_pkg::ascii_t   name_char,
   output text_overlay_pkg::ascii_t   move_char
);

   localparam int NAME_CHARS = text_overlay_pkg::NAME_LEN;
   localparam int MOVE_CHARS = text_overlay_pkg::MOVE_LEN;

   // creature names, space padded to 9
   // element 0 of each row is the leftmost character
   localparam logic [0:NAME_CHARS-1][7:0] POKE_NAMES [text_overlay_pkg::NUM_POKE] = '{
      "BLASTOISE",
      "CHARIZARD",
      "DRAGONITE",
      "GENGAR   ",
      "MEW      ",
      "PIKACHU  ",
      "VENUSAUR ",
      "WEEZING  "
   };

   // move names, space padded to 12
   localparam logic [0:MOVE_CHARS-1][7:0] MOVE_NAMES [text_overlay_pkg::NUM_MOVES] = '{
      "HYDRO PUMP  ",
      "ICE BEAM    ",
      "CRUNCH      ",
      "AURA SPHERE ",
      "FLAMETHROWER",
      "THUNDERPUNCH",
      "AIR SLASH   ",
      "DRAGON CLAW ",
      "ENERGY BALL ",
      "SLUDGE BOMB ",
      "EARTHQUAKE  ",
      "PETAL DANCE ",
      "THUNDERBOLT ",
      "SLAM        ",
      "SURF        ",
      "THUNDER     ",
      "DARK PULSE  ",
      "SHADOW BALL ",
      "PSYCHIC     ",
      "PLAY ROUGH  ",
      "FLASH CANNON",
      "BUG BUZZ    ",
      "FIRE BLAST  ",
      "ROCK SLIDE  ",
      "DRAGON PULSE",
      "BLIZZARD    "
   };

   // name lookup
   // all 8 ids are populated, only the slot needs a range check
   always_comb begin
      if (name_slot < text_overlay_pkg::slot_t'(NAME_CHARS)) begin
         name_char = POKE_NAMES[poke_id][name_slot];
      end else begin
         name_char = text_overlay_pkg::ASCII_SPACE;
      end
   end

   // move lookup
   // ids 26..31 have no entry and read as blanks
   always_comb begin
      if (move_id < text_overlay_pkg::move_id_t'(text_overlay_pkg::NUM_MOVES) &&
          move_slot < text_overlay_pkg::slot_t'(MOVE_CHARS)) begin
         move_char = MOVE_NAMES[move_id][move_slot];
      end else begin
         move_char = text_overlay_pkg::ASCII_SPACE;
      end
   end

endmodule

/* source/text_field_window.sv */
`timescale 1ns/1ps

module text_field_window #(
   parameter int LENGTH = 9
) (
   input  text_overlay_pkg::coord_t     draw_x,
   input  text_overlay_pkg::coord_t     draw_y,
   input  text_overlay_pkg::coord_t     start_x,
   input  text_overlay_pkg::coord_t     start_y,
   output logic                         in_field,
   output text_overlay_pkg::slot_t      slot,
   output text_overlay_pkg::glyph_col_t glyph_col,
   output text_overlay_pkg::glyph_row_t glyph_row
);

   // field extent in pixels
   localparam text_overlay_pkg::coord_t FIELD_W = text_overlay_pkg::coord_t'(
      LENGTH * text_overlay_pkg::CHAR_W);
   localparam text_overlay_pkg::coord_t FIELD_H = text_overlay_pkg::coord_t'(
      text_overlay_pkg::CHAR_H);
   localparam text_overlay_pkg::coord_t CELL_W = text_overlay_pkg::coord_t'(
      text_overlay_pkg::CHAR_W);

   // offsets from the field origin
   // wrap when the pixel is left of or above the field, so range test covers both
   text_overlay_pkg::coord_t dx;
   text_overlay_pkg::coord_t dy;

   assign dx = draw_x - start_x;
   assign dy = draw_y - start_y;

   always_comb begin
      in_field = (draw_x >= start_x) && (dx < FIELD_W) &&
                 (draw_y >= start_y) && (dy < FIELD_H);
      if (in_field) begin
         // cell index and column inside the cell
         slot = text_overlay_pkg::slot_t'(dx / CELL_W);
         glyph_col = text_overlay_pkg::glyph_col_t'(dx % CELL_W);
         // dy < 16 here so the low bits are the whole row
         glyph_row = text_overlay_pkg::glyph_row_t'(dy);
      end else begin
         slot = '0;
         glyph_col = '0;
         glyph_row = '0;
      end
   end

endmodule

/* source/text_overlay.sv */
`timescale 1ns/1ps

module text_overlay #(
   parameter int NAME_LEN = text_overlay_pkg::NAME_LEN,
   parameter int MOVE_LEN = text_overlay_pkg::MOVE_LEN,
   parameter int HP_LEN = text_overlay_pkg::HP_LEN
) (
   input  logic                         clk,
   input  logic                         rst,
   input  text_overlay_pkg::coord_t     draw_x,
   input  text_overlay_pkg::coord_t     draw_y,
   input  text_overlay_pkg::coord_t     name_x,
   input  text_overlay_pkg::coord_t     name_y,
   input  text_overlay_pkg::coord_t     move_x,
   input  text_overlay_pkg::coord_t     move_y,
   input  text_overlay_pkg::coord_t     hp_x,
   input  text_overlay_pkg::coord_t     hp_y,
   input  text_overlay_pkg::poke_id_t   poke_id,
   input  text_overlay_pkg::move_id_t   move_id,
   input  text_overlay_pkg::hp_t        cur_hp,
   input  text_overlay_pkg::hp_t        max_hp,
   output logic                         text_on,
   output text_overlay_pkg::ascii_t     char_code,
   output text_overlay_pkg::glyph_col_t glyph_col,
   output text_overlay_pkg::glyph_row_t glyph_row,
   output text_overlay_pkg::field_t     field
);

   // per-field window results
   logic name_hit;
   logic move_hit;
   logic hp_hit;
   text_overlay_pkg::slot_t name_slot;
   text_overlay_pkg::slot_t move_slot;
   text_overlay_pkg::slot_t hp_slot;
   text_overlay_pkg::glyph_col_t name_col;
   text_overlay_pkg::glyph_col_t move_col;
   text_overlay_pkg::glyph_col_t hp_col;
   text_overlay_pkg::glyph_row_t name_row;
   text_overlay_pkg::glyph_row_t move_row;
   text_overlay_pkg::glyph_row_t hp_row;

   // characters at the current slots
   text_overlay_pkg::ascii_t name_char;
   text_overlay_pkg::ascii_t move_char;
   text_overlay_pkg::ascii_t hp_char;

   // winning field, before the register
   logic                         nxt_on;
   text_overlay_pkg::ascii_t     nxt_char;
   text_overlay_pkg::glyph_col_t nxt_col;
   text_overlay_pkg::glyph_row_t nxt_row;
   text_overlay_pkg::field_t     nxt_field;

   // one window per field, all share the same draw position
   text_field_window #(.LENGTH(NAME_LEN)) name_win (
      .draw_x    (draw_x),
      .draw_y    (draw_y),
      .start_x   (name_x),
      .start_y   (name_y),
      .in_field  (name_hit),
      .slot      (name_slot),
      .glyph_col (name_col),
      .glyph_row (name_row)
   );

   text_field_window #(.LENGTH(MOVE_LEN)) move_win (
      .draw_x    (draw_x),
      .draw_y    (draw_y),
      .start_x   (move_x),
      .start_y   (move_y),
      .in_field  (move_hit),
      .slot      (move_slot),
      .glyph_col (move_col),
      .glyph_row (move_row)
   );

   text_field_window #(.LENGTH(HP_LEN)) hp_win (
      .draw_x    (draw_x),
      .draw_y    (draw_y),
      .start_x   (hp_x),
      .start_y   (hp_y),
      .in_field  (hp_hit),
      .slot      (hp_slot),
      .glyph_col (hp_col),
      .glyph_row (hp_row)
   );

   // name and move strings
   name_rom names_i (
      .poke_id   (poke_id),
      .name_slot (name_slot),
      .move_id   (move_id),
      .move_slot (move_slot),
      .name_char (name_char),
      .move_char (move_char)
   );

   // "ccc/mmm" digits
   hp_digit_format hp_fmt_i (
      .cur_hp  (cur_hp),
      .max_hp  (max_hp),
      .slot    (hp_slot),
      .hp_char (hp_char)
   );

   // priority name > move > hp
   always_comb begin
      nxt_on = 1'b1;
      if (name_hit) begin
         nxt_char = name_char;
         nxt_col = name_col;
         nxt_row = name_row;
         nxt_field = text_overlay_pkg::FIELD_NAME;
      end else if (move_hit) begin
         nxt_char = move_char;
         nxt_col = move_col;
         nxt_row = move_row;
         nxt_field = text_overlay_pkg::FIELD_MOVE;
      end else if (hp_hit) begin
         nxt_char = hp_char;
         nxt_col = hp_col;
         nxt_row = hp_row;
         nxt_field = text_overlay_pkg::FIELD_HP;
      end else begin
         // background pixel, blank glyph
         nxt_on = 1'b0;
         nxt_char = text_overlay_pkg::ASCII_SPACE;
         nxt_col = '0;
         nxt_row = '0;
         nxt_field = text_overlay_pkg::FIELD_NONE;
      end
   end

   // single pixel stage toward the font lookup
   always_ff @(posedge clk) begin
      if (rst) begin
         text_on <= 1'b0;
         char_code <= text_overlay_pkg::ASCII_SPACE;
         glyph_col <= '0;
         glyph_row <= '0;
         field <= text_overlay_pkg::FIELD_NONE;
      end else begin
         text_on <= nxt_on;
         char_code <= nxt_char;
         glyph_col <= nxt_col;
         glyph_row <= nxt_row;
         field <= nxt_field;
      end
   end

endmodule

/* source/text_overlay_pkg.sv */
package text_overlay_pkg;

   // raster coordinate, also used for field start positions
   typedef logic [9:0] coord_t;

   // character code fed to the font lookup
   typedef logic [7:0] ascii_t;

   // pixel position inside one 8x16 glyph
   typedef logic [2:0] glyph_col_t;
   typedef logic [3:0] glyph_row_t;

   // character index inside a field, 12 slots max
   typedef logic [3:0] slot_t;

   // table selectors
   typedef logic [2:0] poke_id_t;
   typedef logic [4:0] move_id_t;

   // hit points, 0 to 199 in practice
   typedef logic [7:0] hp_t;

   // which field the pixel belongs to
   typedef logic [1:0] field_t;

   // glyph cell size in pixels
   localparam int CHAR_W = 8;
   localparam int CHAR_H = 16;

   // field lengths in characters
   localparam int NAME_LEN = 9;
   localparam int MOVE_LEN = 12;
   // "ccc/mmm"
   localparam int HP_LEN = 7;

   // table depths
   localparam int NUM_POKE = 8;
   localparam int NUM_MOVES = 26;

   // characters used outside the name tables
   localparam ascii_t ASCII_SPACE = 8'h20;
   localparam ascii_t ASCII_ZERO = 8'h30;
   localparam ascii_t ASCII_ONE = 8'h31;
   localparam ascii_t ASCII_SLASH = 8'h2f;

   // field codes, NONE when nothing is drawn
   localparam field_t FIELD_NONE = 2'd0;
   localparam field_t FIELD_NAME = 2'd1;
   localparam field_t FIELD_MOVE = 2'd2;
   localparam field_t FIELD_HP = 2'd3;

endpackage

/* tests/text_overlay_asserts.sv */
`timescale 1ns/1ps

module text_overlay_asserts (
   input logic                         clk,
   input logic                         rst,
   input logic                         name_hit,
   input logic                         move_hit,
   input logic                         hp_hit,
   input logic                         text_on,
   input text_overlay_pkg::ascii_t     char_code,
   input text_overlay_pkg::glyph_col_t glyph_col,
   input text_overlay_pkg::glyph_row_t glyph_row,
   input text_overlay_pkg::field_t     field
);

   // one counter per assertion, summed for the testbench
   int reset_fails = 0;
   int blank_fails = 0;
   int code_fails = 0;
   int flow_fails = 0;
   int prio_fails = 0;
   int fail_count;
   logic any_hit;

   assign any_hit = name_hit || move_hit || hp_hit;
   assign fail_count = reset_fails + blank_fails + code_fails + flow_fails + prio_fails;

   // reset loads the blank pixel
   reset_blank: assert property (@(posedge clk)
      rst |=> (!text_on && field == text_overlay_pkg::FIELD_NONE &&
               char_code == text_overlay_pkg::ASCII_SPACE))
      else begin
         reset_fails++;
         $error("outputs not blank after a reset cycle");
      end

   // background pixel carries the defaults
   off_defaults: assert property (@(posedge clk) disable iff (rst)
      !text_on |-> (char_code == text_overlay_pkg::ASCII_SPACE &&
                    glyph_col == '0 && glyph_row == '0))
      else begin
         blank_fails++;
         $error("text_on low but char_code or glyph position not at default");
      end

   // field code and text_on agree
   code_matches_on: assert property (@(posedge clk) disable iff (rst)
      text_on == (field != text_overlay_pkg::FIELD_NONE))
      else begin
         code_fails++;
         $error("field code disagrees with text_on");
      end

   // one pixel per cycle, exactly one cycle late
   one_cycle_flow: assert property (@(posedge clk)
      !rst |=> (text_on == $past(any_hit)))
      else begin
         flow_fails++;
         $error("text_on does not follow the window hit of the previous cycle");
      end

   // name over move over hp
   name_first: assert property (@(posedge clk)
      (!rst && name_hit) |=> (field == text_overlay_pkg::FIELD_NAME))
      else begin
         prio_fails++;
         $error("name window hit but field is not the name field");
      end

   move_second: assert property (@(posedge clk)
      (!rst && !name_hit && move_hit) |=> (field == text_overlay_pkg::FIELD_MOVE))
      else begin
         prio_fails++;
         $error("move window hit alone but field is not the move field");
      end

   hp_last: assert property (@(posedge clk)
      (!rst && !name_hit && !move_hit && hp_hit) |=> (field == text_overlay_pkg::FIELD_HP))
      else begin
         prio_fails++;
         $error("hp window hit alone but field is not the hp field");
      end

endmodule

/* tests/text_overlay_tb.sv */
`timescale 1ns/1ps

module text_overlay_tb;

   // pixels per sweep are len*8 + 2, plus one park pixel
   localparam int SWEEP_CYCLES = 10 * 75 + 8 * 99 + 13 * 59 + 73;
   localparam int TIMEOUT_NS = (SWEEP_CYCLES + 8 + 60) * 40;

   logic clk = 1'b0;
   logic rst;
   text_overlay_pkg::coord_t draw_x;
   text_overlay_pkg::coord_t draw_y;
   text_overlay_pkg::coord_t name_x;
   text_overlay_pkg::coord_t name_y;
   text_overlay_pkg::coord_t move_x;
   text_overlay_pkg::coord_t move_y;
   text_overlay_pkg::coord_t hp_x;
   text_overlay_pkg::coord_t hp_y;
   text_overlay_pkg::poke_id_t poke_id;
   text_overlay_pkg::move_id_t move_id;
   text_overlay_pkg::hp_t cur_hp;
   text_overlay_pkg::hp_t max_hp;
   logic text_on;
   text_overlay_pkg::ascii_t char_code;
   text_overlay_pkg::glyph_col_t glyph_col;
   text_overlay_pkg::glyph_row_t glyph_row;
   text_overlay_pkg::field_t field;

   // expected result of the pixel driven last, and one cycle later
   logic exp_on = 1'b0;
   text_overlay_pkg::ascii_t exp_char = 8'h20;
   text_overlay_pkg::glyph_col_t exp_col = '0;
   text_overlay_pkg::glyph_row_t exp_row = '0;
   text_overlay_pkg::field_t exp_field = text_overlay_pkg::FIELD_NONE;
   logic chk_valid = 1'b0;
   logic chk_on;
   text_overlay_pkg::ascii_t chk_char;
   text_overlay_pkg::glyph_col_t chk_col;
   text_overlay_pkg::glyph_row_t chk_row;
   text_overlay_pkg::field_t chk_field;
   int errors = 0;

   // reference strings, same order as the stored tables
   string poke_names [8] = '{"BLASTOISE", "CHARIZARD", "DRAGONITE", "GENGAR   ",
                             "MEW      ", "PIKACHU  ", "VENUSAUR ", "WEEZING  "};
   string move_names [26] = '{
      "HYDRO PUMP  ", "ICE BEAM    ", "CRUNCH      ", "AURA SPHERE ",
      "FLAMETHROWER", "THUNDERPUNCH", "AIR SLASH   ", "DRAGON CLAW ",
      "ENERGY BALL ", "SLUDGE BOMB ", "EARTHQUAKE  ", "PETAL DANCE ",
      "THUNDERBOLT ", "SLAM        ", "SURF        ", "THUNDER     ",
      "DARK PULSE  ", "SHADOW BALL ", "PSYCHIC     ", "PLAY ROUGH  ",
      "FLASH CANNON", "BUG BUZZ    ", "FIRE BLAST  ", "ROCK SLIDE  ",
      "DRAGON PULSE", "BLIZZARD    "};

   text_overlay dut_i (.*);

   bind text_overlay text_overlay_asserts asserts_i (.*);

   always #20 clk = ~clk;

   // "ccc/mmm", current tens blank below 10, max tens always shown
   function automatic string hp_string(int cur, int max);
      string cur_h;
      string cur_t;
      string max_h;
      cur_h = " ";
      max_h = " ";
      cur_t = " ";
      if (cur >= 100) begin
         cur_h = "1";
      end
      if (max >= 100) begin
         max_h = "1";
      end
      if (cur >= 10) begin
         cur_t = $sformatf("%0d", (cur % 100) / 10);
      end
      return $sformatf("%s%s%0d/%s%0d%0d", cur_h, cur_t, cur % 10, max_h,
                       (max % 100) / 10, max % 10);
   endfunction

   task automatic check_value(string sig, int expected, int actual);
      assert (expected == actual) else begin
         $display("Mismatch at %0t ns: %s expected %0h, actual %0h", $time, sig,
                  expected, actual);
         errors++;
      end
   endtask

   // new pixel 2 ns after the edge
   task automatic drive_pixel(int x, int y, logic on, text_overlay_pkg::ascii_t ch,
                              text_overlay_pkg::glyph_col_t col,
                              text_overlay_pkg::glyph_row_t row,
                              text_overlay_pkg::field_t f);
      @(posedge clk);
      #2;
      draw_x = text_overlay_pkg::coord_t'(x);
      draw_y = text_overlay_pkg::coord_t'(y);
      exp_on = on;
      exp_char = ch;
      exp_col = col;
      exp_row = row;
      exp_field = f;
   endtask

   // one raster row from x_lo to x_hi, then park on background
   task automatic sweep_span(text_overlay_pkg::field_t fcode, int fx, int fy, string text,
                             int y, int x_lo, int x_hi);
      int dx;
      int dy;
      dy = y - fy;
      for (int x = x_lo; x <= x_hi; x++) begin
         dx = x - fx;
         if (dx >= 0 && dx < text.len() * 8 && dy >= 0 && dy < 16) begin
            drive_pixel(x, y, 1'b1, text[dx / 8], text_overlay_pkg::glyph_col_t'(dx % 8),
                        text_overlay_pkg::glyph_row_t'(dy), fcode);
         end else begin
            drive_pixel(x, y, 1'b0, 8'h20, '0, '0, text_overlay_pkg::FIELD_NONE);
         end
      end
      drive_pixel(0, 0, 1'b0, 8'h20, '0, '0, text_overlay_pkg::FIELD_NONE);
   endtask

   // one column before the field to one column past it
   task automatic sweep_field(text_overlay_pkg::field_t fcode, int fx, int fy, string text,
                              int y);
      sweep_span(fcode, fx, fy, text, y, fx - 1, fx + text.len() * 8);
   endtask

   always @(posedge clk) begin
      chk_valid <= !rst;
      chk_on <= exp_on;
      chk_char <= exp_char;
      chk_col <= exp_col;
      chk_row <= exp_row;
      chk_field <= exp_field;
   end

   // mid-cycle, outputs settled
   always @(negedge clk) begin
      if (chk_valid) begin
         check_value("text_on", int'(chk_on), int'(text_on));
         check_value("char_code", int'(chk_char), int'(char_code));
         check_value("glyph_col", int'(chk_col), int'(glyph_col));
         check_value("glyph_row", int'(chk_row), int'(glyph_row));
         check_value("field", int'(chk_field), int'(field));
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int edge_hp [7] = '{0, 5, 10, 99, 100, 150, 199};
      int mv;
      void'($urandom(32'hbce3411b));
      rst = 1'b1;
      // fields kept apart
      name_x = 10'd40;
      name_y = 10'd40;
      move_x = 10'd40;
      move_y = 10'd200;
      hp_x = 10'd400;
      hp_y = 10'd300;
      poke_id = '0;
      move_id = '0;
      cur_hp = '0;
      max_hp = '0;
      // pixel inside the name field, only the reset keeps the outputs blank
      draw_x = name_x;
      draw_y = name_y;
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;
      draw_x = '0;
      draw_y = '0;
      // every creature, a different glyph row each
      for (int id = 0; id < 8; id++) begin
         poke_id = text_overlay_pkg::poke_id_t'(id);
         sweep_field(text_overlay_pkg::FIELD_NAME, int'(name_x), int'(name_y),
                     poke_names[id], int'(name_y) + 2 * id);
      end
      sweep_field(text_overlay_pkg::FIELD_NAME, int'(name_x), int'(name_y),
                  poke_names[7], int'(name_y) + 15);
      // first row below the field
      sweep_field(text_overlay_pkg::FIELD_NAME, int'(name_x), int'(name_y),
                  poke_names[7], int'(name_y) + 16);
      for (int n = 0; n < 8; n++) begin
         mv = int'($urandom % 26);
         move_id = text_overlay_pkg::move_id_t'(mv);
         sweep_field(text_overlay_pkg::FIELD_MOVE, int'(move_x), int'(move_y),
                     move_names[mv], int'(move_y) + int'($urandom % 16));
      end
      // edge pairs first, then random values
      for (int n = 0; n < 13; n++) begin
         if (n < 7) begin
            cur_hp = text_overlay_pkg::hp_t'(edge_hp[n]);
            max_hp = text_overlay_pkg::hp_t'(edge_hp[6 - n]);
         end else begin
            cur_hp = text_overlay_pkg::hp_t'($urandom % 200);
            max_hp = text_overlay_pkg::hp_t'($urandom % 200);
         end
         sweep_field(text_overlay_pkg::FIELD_HP, int'(hp_x), int'(hp_y),
                     hp_string(int'(cur_hp), int'(max_hp)), int'(hp_y) + int'($urandom % 16));
      end
      // move field slid under the name field
      move_x = name_x + 10'd24;
      move_y = name_y + 10'd4;
      poke_id = 3'd5;
      sweep_span(text_overlay_pkg::FIELD_NAME, int'(name_x), int'(name_y), poke_names[5],
                 int'(name_y) + 8, int'(name_x), int'(name_x) + 71);
      move_x = 10'd40;
      move_y = 10'd200;
      repeat (3) @(negedge clk);
      #1;
      $display("errors: %0d value mismatches, %0d assertion failures", errors,
               dut_i.asserts_i.fail_count);
      if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
